// File: src/rv32i_pkg.sv
//////////////////////////////
// Core widths, opcodes, instruction classes
// and the bus structs shared by all blocks
//////////////////////////////

package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STATUS_W   = 8;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam xlen_t BOOT_ADDR = '0;

    // Status bus layout, other bits tied low
    localparam int ECALL_BIT   = 0;
    localparam int EBREAK_BIT  = 1;
    localparam int ILLEGAL_BIT = 3;

    //////////////////////////////
    // Major opcodes
    //////////////////////////////
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_OP_IMM,
        CLS_OP,
        CLS_STORE,
        CLS_ECALL,
        CLS_EBREAK,
        CLS_ILLEGAL
    } inst_class_e;

    //////////////////////////////
    // Buses
    //////////////////////////////
    typedef struct packed {
        inst_class_e iclass;
        logic [2:0]  funct3;
        logic        alt;       // funct7 bit 5
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        xlen_t       imm;
        logic        wr_rd;
    } inst_bus_t;

    typedef struct packed {
        logic  valid;
        xlen_t addr;
    } imem_req_t;

    typedef struct packed {
        logic            valid;
        logic [ILEN-1:0] data;
    } imem_rsp_t;

    typedef struct packed {
        logic  valid;
        xlen_t addr;
        xlen_t data;
    } dmem_wr_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        xlen_t     data;
    } rd_wr_t;

endpackage

// File: src/rv32i_decoder.sv
//////////////////////////////
// Instruction decoder, word to decoded bus
//////////////////////////////

`timescale 1ns/1ns

module rv32i_decoder (
    input  rv32i_pkg::xlen_t     inst_word,
    output rv32i_pkg::inst_bus_t inst
);
    import rv32i_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode = inst_word[6:0];
    assign funct3 = inst_word[14:12];
    assign funct7 = inst_word[31:25];

    // Immediate formats, all sign-extended from bit 31
    assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
    assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
    assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                    inst_word[30:25], inst_word[11:8], 1'b0};
    assign imm_u = {inst_word[31:12], 12'b0};
    assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                    inst_word[20], inst_word[30:21], 1'b0};

    always_comb begin
        inst        = '0;
        inst.funct3 = funct3;
        inst.alt    = inst_word[30];
        inst.rs1    = inst_word[19:15];
        inst.rs2    = inst_word[24:20];
        inst.rd     = inst_word[11:7];
        inst.iclass = CLS_ILLEGAL;
        case (opcode)
            OPC_LUI: begin
                inst.iclass = CLS_LUI;
                inst.imm    = imm_u;
            end
            OPC_AUIPC: begin
                inst.iclass = CLS_AUIPC;
                inst.imm    = imm_u;
            end
            OPC_JAL: begin
                inst.iclass = CLS_JAL;
                inst.imm    = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) inst.iclass = CLS_JALR;
                inst.imm = imm_i;
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) inst.iclass = CLS_BRANCH;
                inst.imm = imm_b;
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
                    inst.iclass = CLS_ILLEGAL;
                end else if (funct3 == 3'b101 && funct7 != 7'b0000000
                             && funct7 != 7'b0100000) begin
                    inst.iclass = CLS_ILLEGAL;
                end else begin
                    inst.iclass = CLS_OP_IMM;
                end
                inst.imm = imm_i;
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    inst.iclass = CLS_OP;
                end else if (funct7 == 7'b0100000 &&
                             (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    inst.iclass = CLS_OP;
                end
            end
            OPC_STORE: begin
                // Full word only
                if (funct3 == 3'b010) inst.iclass = CLS_STORE;
                inst.imm = imm_s;
            end
            OPC_SYSTEM: begin
                if (inst_word == 32'h0000_0073) inst.iclass = CLS_ECALL;
                if (inst_word == 32'h0010_0073) inst.iclass = CLS_EBREAK;
            end
            default: inst.iclass = CLS_ILLEGAL;
        endcase
        inst.wr_rd = inst.iclass inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
                                         CLS_OP_IMM, CLS_OP};
    end

endmodule

// File: src/rv32i_registers.sv
//////////////////////////////
// Integer register file, 2R1W
//////////////////////////////

`timescale 1ns/1ns

module rv32i_registers (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  rv32i_pkg::reg_addr_t rs_addr1,
    input  rv32i_pkg::reg_addr_t rs_addr2,
    output rv32i_pkg::xlen_t     rs_val1,
    output rv32i_pkg::xlen_t     rs_val2,
    input  rv32i_pkg::rd_wr_t    rd_wr
);
    import rv32i_pkg::*;

    // x0 is cleared on reset and never written
    xlen_t regs [0:2**REG_ADDR_W-1];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr.en && rd_wr.addr != '0) begin
            regs[rd_wr.addr] <= rd_wr.data;
        end
    end

    // Combinational reads
    assign rs_val1 = regs[rs_addr1];
    assign rs_val2 = regs[rs_addr2];

    // x0 reads as zero, even right after a write aimed at it
    x0_zero: assert property (@(posedge aclk) disable iff (!rst_n)
        (rs_addr1 == '0 |-> rs_val1 == '0) and (rs_addr2 == '0 |-> rs_val2 == '0));

endmodule

// File: src/rv32i_execute.sv
//////////////////////////////
// ALU, branch test, next pc
//////////////////////////////

`timescale 1ns/1ns

module rv32i_execute (
    input  rv32i_pkg::inst_bus_t inst,
    input  rv32i_pkg::xlen_t     rs_val1,
    input  rv32i_pkg::xlen_t     rs_val2,
    input  rv32i_pkg::xlen_t     pc,
    output rv32i_pkg::xlen_t     result,
    output rv32i_pkg::xlen_t     next_pc
);
    import rv32i_pkg::*;

    xlen_t      op_b;
    xlen_t      alu_res;
    xlen_t      pc_plus4;
    logic [4:0] shamt;
    logic       taken;

    // Second operand is rs2 for OP, immediate for OP-IMM
    assign op_b     = (inst.iclass == CLS_OP) ? rs_val2 : inst.imm;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (inst.funct3)
            3'b000: begin
                // SUB only exists in the register form
                if (inst.iclass == CLS_OP && inst.alt) alu_res = rs_val1 - op_b;
                else alu_res = rs_val1 + op_b;
            end
            3'b001: alu_res = rs_val1 << shamt;
            3'b010: alu_res = {31'b0, $signed(rs_val1) < $signed(op_b)};
            3'b011: alu_res = {31'b0, rs_val1 < op_b};
            3'b100: alu_res = rs_val1 ^ op_b;
            3'b101: begin
                if (inst.alt) alu_res = $unsigned($signed(rs_val1) >>> shamt);
                else alu_res = rs_val1 >> shamt;
            end
            3'b110: alu_res = rs_val1 | op_b;
            default: alu_res = rs_val1 & op_b;
        endcase
    end

    // Branch condition
    always_comb begin
        case (inst.funct3)
            3'b000: taken = rs_val1 == rs_val2;
            3'b001: taken = rs_val1 != rs_val2;
            3'b100: taken = $signed(rs_val1) < $signed(rs_val2);
            3'b101: taken = $signed(rs_val1) >= $signed(rs_val2);
            3'b110: taken = rs_val1 < rs_val2;
            3'b111: taken = rs_val1 >= rs_val2;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = pc_plus4;
        case (inst.iclass)
            CLS_LUI: result = inst.imm;
            CLS_AUIPC: result = pc + inst.imm;
            CLS_JAL, CLS_JALR: result = pc_plus4;
            CLS_OP, CLS_OP_IMM: result = alu_res;
            CLS_STORE: result = rs_val1 + inst.imm;
            default: result = '0;
        endcase
        if (inst.iclass == CLS_JAL) next_pc = pc + inst.imm;
        if (inst.iclass == CLS_JALR) next_pc = (rs_val1 + inst.imm) & ~32'd1;
        if (inst.iclass == CLS_BRANCH && taken) next_pc = pc + inst.imm;
    end

endmodule

// File: src/rv32i_control.sv
//////////////////////////////
// Fetch/execute/store sequencer, pc, trap status
//////////////////////////////

`timescale 1ns/1ns

module rv32i_control (
    input  logic                           aclk,
    input  logic                           rst_n,
    output rv32i_pkg::imem_req_t           imem_req,
    input  logic                           imem_arready,
    input  rv32i_pkg::imem_rsp_t           imem_rsp,
    output logic                           imem_rready,
    output rv32i_pkg::dmem_wr_t            dmem_wr,
    input  logic                           dmem_wready,
    output rv32i_pkg::xlen_t               inst_word,
    input  rv32i_pkg::inst_bus_t           inst,
    output rv32i_pkg::reg_addr_t           rs_addr1,
    output rv32i_pkg::reg_addr_t           rs_addr2,
    input  rv32i_pkg::xlen_t               rs_val2,
    output rv32i_pkg::rd_wr_t              rd_wr,
    output rv32i_pkg::xlen_t               pc,
    input  rv32i_pkg::xlen_t               result,
    input  rv32i_pkg::xlen_t               next_pc,
    output logic [rv32i_pkg::STATUS_W-1:0] status
);
    import rv32i_pkg::*;

    typedef enum logic [2:0] {FETCH, WAIT, EXECUTE, STORE, HALT} state_e;

    state_e state;
    logic   ar_valid;
    logic   w_valid;
    xlen_t  st_addr;
    xlen_t  st_data;
    logic   is_trap;
    logic   is_store;

    assign is_trap  = inst.iclass inside {CLS_ECALL, CLS_EBREAK, CLS_ILLEGAL};
    assign is_store = inst.iclass == CLS_STORE;

    // pc only moves in EXECUTE, so the fetch address is stable in FETCH
    assign imem_req.valid = ar_valid;
    assign imem_req.addr  = pc;

    assign dmem_wr.valid = w_valid;
    assign dmem_wr.addr  = st_addr;
    assign dmem_wr.data  = st_data;

    assign rs_addr1   = inst.rs1;
    assign rs_addr2   = inst.rs2;
    assign rd_wr.en   = (state == EXECUTE) && inst.wr_rd;
    assign rd_wr.addr = inst.rd;
    assign rd_wr.data = result;

    //////////////////////////////
    // Sequencer
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state       <= FETCH;
            ar_valid    <= 1'b0;
            imem_rready <= 1'b0;
            w_valid     <= 1'b0;
            pc          <= BOOT_ADDR;
            status      <= '0;
        end else begin
            case (state)
                FETCH: begin
                    if (ar_valid && imem_arready) begin
                        ar_valid    <= 1'b0;
                        imem_rready <= 1'b1;
                        state       <= WAIT;
                    end else begin
                        ar_valid <= 1'b1;
                    end
                end
                WAIT: begin
                    if (imem_rsp.valid && imem_rready) begin
                        imem_rready <= 1'b0;
                        state       <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_trap) begin
                        // Sticky until reset, fetch stops here
                        if (inst.iclass == CLS_ECALL) status[ECALL_BIT] <= 1'b1;
                        if (inst.iclass == CLS_EBREAK) status[EBREAK_BIT] <= 1'b1;
                        if (inst.iclass == CLS_ILLEGAL) status[ILLEGAL_BIT] <= 1'b1;
                        state <= HALT;
                    end else begin
                        pc <= next_pc;
                        if (is_store) begin
                            w_valid <= 1'b1;
                            state   <= STORE;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= FETCH;
                        end
                    end
                end
                STORE: begin
                    if (dmem_wready) begin
                        w_valid  <= 1'b0;
                        ar_valid <= 1'b1;
                        state    <= FETCH;
                    end
                end
                default: state <= HALT;
            endcase
        end
    end

    // Instruction word and store payload
    always_ff @(posedge aclk) begin
        if (state == WAIT && imem_rsp.valid && imem_rready) begin
            inst_word <= imem_rsp.data;
        end
        if (state == EXECUTE && is_store) begin
            st_addr <= result;
            st_data <= rs_val2;
        end
    end

    //////////////////////////////
    // Handshake stability
    //////////////////////////////
    fetch_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        imem_req.valid && !imem_arready |=> imem_req.valid && $stable(imem_req.addr));

    store_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        dmem_wr.valid && !dmem_wready |=>
            dmem_wr.valid && $stable(dmem_wr.addr) && $stable(dmem_wr.data));

endmodule

// File: src/rv32i_core.sv
//////////////////////////////
// RV32I core top level
//////////////////////////////

`timescale 1ns/1ns

module rv32i_core (
    input  logic                           aclk,
    input  logic                           rst_n,
    output rv32i_pkg::imem_req_t           imem_req,
    input  logic                           imem_arready,
    input  rv32i_pkg::imem_rsp_t           imem_rsp,
    output logic                           imem_rready,
    output rv32i_pkg::dmem_wr_t            dmem_wr,
    input  logic                           dmem_wready,
    output logic [rv32i_pkg::STATUS_W-1:0] status
);
    import rv32i_pkg::*;

    xlen_t     inst_word;
    inst_bus_t inst;
    reg_addr_t rs_addr1;
    reg_addr_t rs_addr2;
    xlen_t     rs_val1;
    xlen_t     rs_val2;
    rd_wr_t    rd_wr;
    xlen_t     pc;
    xlen_t     result;
    xlen_t     next_pc;

    // Sequencer, owns pc and the memory handshakes
    rv32i_control control (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_arready (imem_arready),
        .imem_rsp     (imem_rsp),
        .imem_rready  (imem_rready),
        .dmem_wr      (dmem_wr),
        .dmem_wready  (dmem_wready),
        .inst_word    (inst_word),
        .inst         (inst),
        .rs_addr1     (rs_addr1),
        .rs_addr2     (rs_addr2),
        .rs_val2      (rs_val2),
        .rd_wr        (rd_wr),
        .pc           (pc),
        .result       (result),
        .next_pc      (next_pc),
        .status       (status)
    );

    rv32i_decoder decoder (
        .inst_word (inst_word),
        .inst      (inst)
    );

    rv32i_registers isa_registers (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .rs_addr1 (rs_addr1),
        .rs_addr2 (rs_addr2),
        .rs_val1  (rs_val1),
        .rs_val2  (rs_val2),
        .rd_wr    (rd_wr)
    );

    rv32i_execute execute (
        .inst    (inst),
        .rs_val1 (rs_val1),
        .rs_val2 (rs_val2),
        .pc      (pc),
        .result  (result),
        .next_pc (next_pc)
    );

endmodule

// File: verif/rv32i_core_tb.sv
//////////////////////////////
// Testbench for the RV32I core with memory models,
// stimulus file reader, checks and watchdog
//////////////////////////////

`timescale 1ns/1ns

module rv32i_core_tb;
    import rv32i_pkg::*;

    localparam STIM_FILE = "verif/core_stimulus.txt";
    localparam logic [31:0] SEED = 32'h7e96_5abc;
    localparam int CYCLES_PER_WORD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES = 20;

    logic                aclk         = 1'b0;
    logic                rst_n        = 1'b0;
    imem_req_t           imem_req;
    logic                imem_arready = 1'b0;
    imem_rsp_t           imem_rsp     = '0;
    logic                imem_rready;
    dmem_wr_t            dmem_wr;
    logic                dmem_wready  = 1'b0;
    logic [STATUS_W-1:0] status;

    // Program memory and what the program should produce
    xlen_t               imem [xlen_t];
    xlen_t               exp_addr [$];
    xlen_t               exp_data [$];
    logic [STATUS_W-1:0] exp_status;

    // Handshake delays, drawn once from the seeded generator
    logic [1:0] delay_pool [0:255];
    logic [7:0] ar_idx = 8'd0;
    logic [7:0] r_idx  = 8'd85;
    logic [7:0] w_idx  = 8'd170;
    logic [1:0] ar_delay;
    logic [1:0] r_delay;
    logic [1:0] w_delay;

    logic  first_fetch;
    logic  req_held;
    xlen_t held_addr;
    logic  rsp_pending;
    xlen_t rsp_word;
    logic  wr_held;
    xlen_t held_waddr;
    xlen_t held_wdata;
    int    wd_cycles = 0;

    rv32i_core DUT (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_arready (imem_arready),
        .imem_rsp     (imem_rsp),
        .imem_rready  (imem_rready),
        .dmem_wr      (dmem_wr),
        .dmem_wready  (dmem_wready),
        .status       (status)
    );

    initial begin
        forever #5 aclk = ~aclk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string msg);
        fail_run($sformatf("** Error @ %0t ns: %s", $time, msg));
    endtask

    // Sizes the watchdog before any program runs
    task automatic count_records(output int n_words, output int n_programs);
        int    fd;
        string line;
        n_words    = 0;
        n_programs = 0;
        fd = $fopen(STIM_FILE, "r");
        assert (fd != 0) else fail_run("Cannot open the stimulus file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] == "P") n_words++;
            if (line.len() > 0 && line[0] == "E") n_programs++;
        end
        $fclose(fd);
    endtask

    task automatic run_program();
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
        // Every program ends in a trap
        while (status == '0) @(posedge aclk);
        assert (status == exp_status)
            else flag_mismatch($sformatf("status %h, expected %h", status, exp_status));
        repeat (IDLE_CYCLES) begin
            @(posedge aclk);
            assert (!imem_req.valid)
                else flag_mismatch($sformatf("fetch at %h after a trap", imem_req.addr));
        end
        assert (exp_addr.size() == 0)
            else fail_run($sformatf("Program halted with %0d expected stores missing",
                                    exp_addr.size()));
        rst_n <= 1'b0;
        imem.delete();
    endtask

    //////////////////////////////
    // Instruction memory model
    //////////////////////////////
    always @(posedge aclk) begin
        if (!rst_n) begin
            imem_arready <= 1'b0;
            imem_rsp     <= '0;
            rsp_pending  <= 1'b0;
            req_held     <= 1'b0;
            first_fetch  <= 1'b1;
            ar_delay     <= delay_pool[ar_idx];
            ar_idx       <= ar_idx + 8'd1;
            r_delay      <= delay_pool[r_idx];
            r_idx        <= r_idx + 8'd1;
        end else begin
            if (req_held) begin
                assert (imem_req.valid && imem_req.addr == held_addr)
                    else flag_mismatch($sformatf("pending fetch at %h changed to %h",
                                                 held_addr, imem_req.addr));
            end
            if (imem_req.valid && imem_arready) begin
                assert (!first_fetch || imem_req.addr == BOOT_ADDR)
                    else flag_mismatch($sformatf("first fetch at %h, expected %h",
                                                 imem_req.addr, BOOT_ADDR));
                assert (imem.exists(imem_req.addr))
                    else fail_run($sformatf("Fetch from %h, where no instruction was loaded",
                                            imem_req.addr));
                first_fetch  <= 1'b0;
                req_held     <= 1'b0;
                imem_arready <= 1'b0;
                rsp_word     <= imem[imem_req.addr];
                rsp_pending  <= 1'b1;
                ar_delay     <= delay_pool[ar_idx];
                ar_idx       <= ar_idx + 8'd1;
            end else if (imem_req.valid) begin
                req_held  <= 1'b1;
                held_addr <= imem_req.addr;
                if (ar_delay == 2'd0) imem_arready <= 1'b1;
                else ar_delay <= ar_delay - 2'd1;
            end
            // Response side, one word in flight at most
            if (imem_rsp.valid && imem_rready) begin
                imem_rsp.valid <= 1'b0;
            end else if (rsp_pending && !imem_rsp.valid) begin
                if (r_delay == 2'd0) begin
                    imem_rsp.valid <= 1'b1;
                    imem_rsp.data  <= rsp_word;
                    rsp_pending    <= 1'b0;
                    r_delay        <= delay_pool[r_idx];
                    r_idx          <= r_idx + 8'd1;
                end else begin
                    r_delay <= r_delay - 2'd1;
                end
            end
        end
    end

    //////////////////////////////
    // Data write model
    //////////////////////////////
    always @(posedge aclk) begin
        if (!rst_n) begin
            dmem_wready <= 1'b0;
            wr_held     <= 1'b0;
            w_delay     <= delay_pool[w_idx];
            w_idx       <= w_idx + 8'd1;
        end else begin
            if (wr_held) begin
                assert (dmem_wr.valid && dmem_wr.addr == held_waddr &&
                        dmem_wr.data == held_wdata)
                    else flag_mismatch("store payload changed before it was accepted");
            end
            if (dmem_wr.valid && dmem_wready) begin
                assert (exp_addr.size() > 0)
                    else fail_run($sformatf("Store of %h to %h that the program does not list",
                                            dmem_wr.data, dmem_wr.addr));
                assert (dmem_wr.addr == exp_addr[0] && dmem_wr.data == exp_data[0])
                    else flag_mismatch($sformatf("store %h to %h, expected %h to %h",
                                                 dmem_wr.data, dmem_wr.addr,
                                                 exp_data[0], exp_addr[0]));
                exp_addr.delete(0);
                exp_data.delete(0);
                dmem_wready <= 1'b0;
                wr_held     <= 1'b0;
                w_delay     <= delay_pool[w_idx];
                w_idx       <= w_idx + 8'd1;
            end else if (dmem_wr.valid) begin
                wr_held    <= 1'b1;
                held_waddr <= dmem_wr.addr;
                held_wdata <= dmem_wr.data;
                if (w_delay == 2'd0) dmem_wready <= 1'b1;
                else w_delay <= w_delay - 2'd1;
            end
        end
    end

    //////////////////////////////
    // Stimulus reader
    //////////////////////////////
    initial begin
        int         fd;
        int         n_fields;
        int         n_words;
        int         n_programs;
        string      line;
        logic [7:0] kind;
        xlen_t      addr;
        xlen_t      value;

        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            delay_pool[i] = 2'($urandom % 4);
        end
        count_records(n_words, n_programs);
        wd_cycles = n_words * CYCLES_PER_WORD + n_programs * (RESET_CYCLES + IDLE_CYCLES + 2);
        fd = $fopen(STIM_FILE, "r");
        assert (fd != 0) else fail_run("Cannot open the stimulus file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 5 || line[0] == "#") continue;
            n_fields = $sscanf(line, "%c %h %h", kind, addr, value);
            assert (n_fields == 3) else fail_run({"Malformed stimulus record ", line});
            case (kind)
                "P": imem[addr] = value;
                "W": begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(value);
                end
                "S": exp_status = value[STATUS_W-1:0];
                "E": run_program();
                default: fail_run({"Unknown record kind in line ", line});
            endcase
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

    // Ends a run that stalls or never traps
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge aclk);
        fail_run("The watchdog expired because the programs did not finish in time");
    end

endmodule

// File: verif/core_stimulus.txt
# kind address value: P loads an instruction word, W is the next expected store (address data)
# S gives the expected final status in the value column, E runs the program and resets the core
# Arithmetic and logic ending in ECALL
P 00000000 123450B7  lui   x1, 0x12345
P 00000004 67808093  addi  x1, x1, 0x678
P 00000008 10102023  sw    x1, 0x100(x0)
P 0000000C FFD00113  addi  x2, x0, -3
P 00000010 402081B3  sub   x3, x1, x2
P 00000014 40115213  srai  x4, x2, 1
P 00000018 0041C2B3  xor   x5, x3, x4
P 0000001C 10302223  sw    x3, 0x104(x0)
P 00000020 10502423  sw    x5, 0x108(x0)
P 00000024 00012333  slt   x6, x2, x0
P 00000028 00431413  slli  x8, x6, 4
P 0000002C 0F02F493  andi  x9, x5, 0xf0
P 00000030 00001517  auipc x10, 1
P 00000034 10802623  sw    x8, 0x10c(x0)
P 00000038 10902823  sw    x9, 0x110(x0)
P 0000003C 10A02A23  sw    x10, 0x114(x0)
P 00000040 00000073  ecall
W 00000100 12345678
W 00000104 1234567B
W 00000108 EDCBA985
W 0000010C 00000010
W 00000110 00000080
W 00000114 00001030
S 00000000 00000001
E 00000000 00000000
# Branches of all six kinds both ways then JAL and JALR ending in EBREAK
# Each fall-through adds its own weight to x5 so a wrong direction changes the sum
P 00000000 00100093  addi  x1, x0, 1
P 00000004 FFF00113  addi  x2, x0, -1
P 00000008 00208463  beq   x1, x2 not taken
P 0000000C 00128293  addi  x5, x5, 1
P 00000010 00209463  bne   x1, x2 taken
P 00000014 00228293  addi  x5, x5, 2
P 00000018 00114463  blt   x2, x1 taken
P 0000001C 00428293  addi  x5, x5, 4
P 00000020 00115463  bge   x2, x1 not taken
P 00000024 00828293  addi  x5, x5, 8
P 00000028 00116463  bltu  x2, x1 not taken
P 0000002C 01028293  addi  x5, x5, 16
P 00000030 00117463  bgeu  x2, x1 taken
P 00000034 02028293  addi  x5, x5, 32
P 00000038 0020C463  blt   x1, x2 not taken
P 0000003C 04028293  addi  x5, x5, 64
P 00000040 0020E463  bltu  x1, x2 taken
P 00000044 08028293  addi  x5, x5, 128
P 00000048 00108463  beq   x1, x1 taken
P 0000004C 10028293  addi  x5, x5, 256
P 00000050 00211463  bne   x2, x2 not taken
P 00000054 20028293  addi  x5, x5, 512
P 00000058 0020D463  bge   x1, x2 taken
P 0000005C 40028293  addi  x5, x5, 1024
P 00000060 0020F463  bgeu  x1, x2 not taken
P 00000064 80028293  addi  x5, x5, -2048
P 00000068 10502023  sw    x5, 0x100(x0)
P 0000006C 00C0036F  jal   x6, +12
P 00000070 10002E23  sw    x0, 0x11c(x0) skipped
P 00000074 10002E23  sw    x0, 0x11c(x0) skipped
P 00000078 10602223  sw    x6, 0x104(x0)
P 0000007C 01D303E7  jalr  x7, 0x1d(x6)
P 00000080 10002E23  sw    x0, 0x11c(x0) skipped
P 00000084 10002E23  sw    x0, 0x11c(x0) skipped
P 00000088 10002E23  sw    x0, 0x11c(x0) skipped
P 0000008C 10702423  sw    x7, 0x108(x0)
P 00000090 00100073  ebreak
W 00000100 FFFFFA59
W 00000104 00000070
W 00000108 00000080
S 00000000 00000002
E 00000000 00000000
# Writes to x0 and a copy of x0 ending in an illegal word
P 00000000 00700093  addi  x1, x0, 7
P 00000004 05500013  addi  x0, x0, 0x55
P 00000008 ABCDE037  lui   x0, 0xabcde
P 0000000C 000000B3  add   x1, x0, x0
P 00000010 10002023  sw    x0, 0x100(x0)
P 00000014 10102223  sw    x1, 0x104(x0)
P 00000018 FFFFFFFF  illegal
W 00000100 00000000
W 00000104 00000000
S 00000000 00000008
E 00000000 00000000

// File: verilog.f
src/rv32i_pkg.sv
src/rv32i_decoder.sv
src/rv32i_registers.sv
src/rv32i_execute.sv
src/rv32i_control.sv
src/rv32i_core.sv
verif/rv32i_core_tb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - src/rv32i_pkg.sv
  - src/rv32i_decoder.sv
  - src/rv32i_registers.sv
  - src/rv32i_execute.sv
  - src/rv32i_control.sv
  - src/rv32i_core.sv
  - target: simulation
    files:
      - verif/rv32i_core_tb.sv
